/* Bender.yml */
package:
  name: debug_top

export_include_dirs:
  - hw

sources:
  - hw/harnessPkg.sv
  - hw/displayPkg.sv
  - hw/inputSampler.sv
  - hw/tickGen.sv
  - hw/intervalTimer.sv
  - hw/probeConfig.sv
  - hw/segDisplay.sv
  - hw/debugTop.sv
  - target: test
    files:
      - verif/debugTop_tb.sv

/* debugTop.f */
+incdir+hw
hw/harnessPkg.sv
hw/displayPkg.sv
hw/inputSampler.sv
hw/tickGen.sv
hw/intervalTimer.sv
hw/probeConfig.sv
hw/segDisplay.sv
hw/debugTop.sv
verif/debugTop_tb.sv

/* hw/debugTop.sv */
`timescale 1ns/1ps
`default_nettype none

module debugTop
(
   input  wire logic               selected_clk,
   input  wire logic               res,
   input  wire logic               btnC,
   input  wire logic               btnU,
   input  wire logic               btnD,
   input  wire logic               btnL,
   input  wire logic               btnR,
   input  wire logic [15:0]        sw,
   output logic [15:0]             leds,
   output displayPkg::segPattern_t seg,
   output displayPkg::anodeVec_t   an
);
   import harnessPkg::*;

   probeInputs_t sample;
   buttonEdges_t edges;
   rateCode_t    rate;
   probeSource_t source;
   timerStatus_t status;
   logic         tick;
   logic [31:0]  probeWord;

   inputSampler sampler
   (
      .selected_clk (selected_clk),
      .res          (res),
      .btnC         (btnC),
      .btnU         (btnU),
      .btnD         (btnD),
      .btnL         (btnL),
      .btnR         (btnR),
      .sw           (sw),
      .sample       (sample),
      .edges        (edges)
   );

   tickGen ticker
   (
      .selected_clk (selected_clk),
      .res          (res),
      .rate         (rate),
      .manualTick   (edges.center),
      .tick         (tick)
   );

   // Up button loads the reload value from the low switches
   intervalTimer timer
   (
      .selected_clk (selected_clk),
      .res          (res),
      .tick         (tick),
      .clear        (edges.down),
      .load         (edges.up),
      .loadValue    ({20'd0, sample.sw[11:0]}),
      .status       (status)
   );

   probeConfig probeCfg
   (
      .selected_clk (selected_clk),
      .res          (res),
      .sample       (sample),
      .edges        (edges),
      .status       (status),
      .rate         (rate),
      .source       (source),
      .probeWord    (probeWord)
   );

   segDisplay display
   (
      .selected_clk (selected_clk),
      .res          (res),
      .word         (probeWord),
      .seg          (seg),
      .an           (an)
   );

   assign leds = {rate, source, status.irqFlag, status.reloadPulse, status.count[5:0]};

endmodule

`default_nettype wire

/* hw/displayPkg.sv */
`default_nettype none
`include "harness_defines.svh"

package displayPkg;

   // Active low, dp in bit 7 and segments g..a below it
   typedef logic [7:0] segPattern_t;

   typedef logic [$clog2(`NUM_DIGITS)-1:0] digitIndex_t;

   // Active low, one bit per digit
   typedef logic [`NUM_DIGITS-1:0] anodeVec_t;

   // Hex font, dp kept dark
   function automatic segPattern_t hexFont(input logic [3:0] nibble);
      case (nibble)
         4'h0: return 8'hC0;
         4'h1: return 8'hF9;
         4'h2: return 8'hA4;
         4'h3: return 8'hB0;
         4'h4: return 8'h99;
         4'h5: return 8'h92;
         4'h6: return 8'h82;
         4'h7: return 8'hF8;
         4'h8: return 8'h80;
         4'h9: return 8'h90;
         4'hA: return 8'h88;
         4'hB: return 8'h83;
         4'hC: return 8'hC6;
         4'hD: return 8'hA1;
         4'hE: return 8'h86;
         default: return 8'h8E;
      endcase
   endfunction

endpackage

`default_nettype wire

/* hw/harnessPkg.sv */
`default_nettype none

package harnessPkg;

   // Button levels and switches as taken on the sample strobe
   typedef struct packed {
      logic        btnC;
      logic        btnU;
      logic        btnD;
      logic        btnL;
      logic        btnR;
      logic [15:0] sw;
   } probeInputs_t;

   // One-cycle rising-edge pulses
   typedef struct packed {
      logic center;
      logic up;
      logic down;
      logic left;
      logic right;
   } buttonEdges_t;

   // Codes 4 to 15 fall back to the manual tick
   typedef enum logic [3:0] {
      rateEvery    = 4'd0,
      rateDiv10    = 4'd1,
      rateDiv100   = 4'd2,
      rateDiv1000  = 4'd3
   } rateCode_t;

   typedef enum logic [3:0] {
      srcCount     = 4'd0,
      srcWrap      = 4'd1,
      srcReload    = 4'd2,
      srcSwitches  = 4'd3,
      srcButtons   = 4'd4,
      srcStatus    = 4'd5,
      srcCycles    = 4'd6
   } probeSource_t;

   typedef struct packed {
      logic [31:0] count;
      logic [31:0] wrapCount;
      logic [31:0] reloadValue;
      logic        reloadPulse;
      logic        irqFlag;
   } timerStatus_t;

endpackage

`default_nettype wire

/* hw/harness_defines.svh */
`ifndef HARNESS_DEFINES_SVH
`define HARNESS_DEFINES_SVH

//////////////////////////////////////////////////////////////
// Strobe dividers
//////////////////////////////////////////////////////////////

// Clock cycles between two input samples
`define SAMPLE_DIV 4

// Ratio between neighbouring tick rates
`define DECADE_DIV 10

//////////////////////////////////////////////////////////////
// Display
//////////////////////////////////////////////////////////////

// Cycles each digit stays lit
`define SCAN_DIV 8
`define NUM_DIGITS 8

`endif

/* hw/inputSampler.sv */
`timescale 1ns/1ps
`default_nettype none
`include "harness_defines.svh"

module inputSampler
(
   input  wire logic                selected_clk,
   input  wire logic                res,
   input  wire logic                btnC,
   input  wire logic                btnU,
   input  wire logic                btnD,
   input  wire logic                btnL,
   input  wire logic                btnR,
   input  wire logic [15:0]         sw,
   output harnessPkg::probeInputs_t sample,
   output harnessPkg::buttonEdges_t edges
);
   import harnessPkg::*;

   localparam int divWidth = ($clog2(`SAMPLE_DIV) > 0) ? $clog2(`SAMPLE_DIV) : 1;

   logic [divWidth-1:0] divCount;
   logic                sampleStrobe;
   logic                sampleFresh;
   probeInputs_t        prevSample;

   assign sampleStrobe = (divCount == divWidth'(`SAMPLE_DIV - 1));

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         divCount <= '0;
      else if (sampleStrobe)
         divCount <= '0;
      else
         divCount <= divCount + 1'b1;
   end

   // Sample, previous sample and edge pulses
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         sample      <= '0;
         prevSample  <= '0;
         sampleFresh <= 1'b0;
         edges       <= '0;
      end
      else
      begin
         sampleFresh <= sampleStrobe;
         if (sampleStrobe)
         begin
            prevSample <= sample;
            sample     <= {btnC, btnU, btnD, btnL, btnR, sw};
         end
         if (sampleFresh)
         begin
            edges.center <= sample.btnC & ~prevSample.btnC;
            edges.up     <= sample.btnU & ~prevSample.btnU;
            edges.down   <= sample.btnD & ~prevSample.btnD;
            edges.left   <= sample.btnL & ~prevSample.btnL;
            edges.right  <= sample.btnR & ~prevSample.btnR;
         end
         else
            edges <= '0;
      end
   end

   // Every pulse drops after one cycle
   edgeSinglePulse: assert property (@(posedge selected_clk) disable iff (res)
      (edges != '0) |=> (edges == '0))
      else $error("inputSampler: edge pulse held for two cycles");

endmodule

`default_nettype wire

/* hw/intervalTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module intervalTimer
(
   input  wire logic                selected_clk,
   input  wire logic                res,
   input  wire logic                tick,
   input  wire logic                clear,
   input  wire logic                load,
   input  wire logic [31:0]         loadValue,
   output harnessPkg::timerStatus_t status
);
   import harnessPkg::*;

   logic [31:0] count;
   logic [31:0] wrapCount;
   logic [31:0] reloadValue;
   logic        reloadPulse;
   logic        irqFlag;
   logic        atReload;

   assign atReload = (count == reloadValue);

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         reloadValue <= '0;
      else if (load)
         reloadValue <= loadValue;
   end

   //////////////////////////////////////////////////////////////
   // Count, wrap and interrupt
   //////////////////////////////////////////////////////////////
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         count       <= '0;
         wrapCount   <= '0;
         reloadPulse <= 1'b0;
         irqFlag     <= 1'b0;
      end
      else
      begin
         reloadPulse <= 1'b0;
         // Clear wins over a tick
         if (clear)
         begin
            count     <= '0;
            wrapCount <= '0;
            irqFlag   <= 1'b0;
         end
         else if (tick)
         begin
            if (atReload)
            begin
               count       <= '0;
               wrapCount   <= wrapCount + 1'b1;
               reloadPulse <= 1'b1;
               irqFlag     <= 1'b1;
            end
            else
               count <= count + 1'b1;
         end
      end
   end

   assign status = '{count: count, wrapCount: wrapCount, reloadValue: reloadValue,
                     reloadPulse: reloadPulse, irqFlag: irqFlag};

   // A tick from inside the range stays inside it
   countInRange: assert property (@(posedge selected_clk) disable iff (res)
      (tick && !clear && !load && count <= reloadValue) |=> (count <= reloadValue))
      else $error("intervalTimer: count passed the reload value");

endmodule

`default_nettype wire

/* hw/probeConfig.sv */
`timescale 1ns/1ps
`default_nettype none

module probeConfig
(
   input  wire logic                     selected_clk,
   input  wire logic                     res,
   input  wire harnessPkg::probeInputs_t sample,
   input  wire harnessPkg::buttonEdges_t edges,
   input  wire harnessPkg::timerStatus_t status,
   output harnessPkg::rateCode_t         rate,
   output harnessPkg::probeSource_t      source,
   output logic [31:0]                   probeWord
);
   import harnessPkg::*;

   logic [31:0] cycleCount;

   // Configuration from the sampled switches
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         rate       <= rateEvery;
         source     <= srcCount;
         cycleCount <= '0;
      end
      else
      begin
         cycleCount <= cycleCount + 1'b1;
         if (edges.right)
            rate <= rateCode_t'(sample.sw[15:12]);
         if (edges.left)
            source <= probeSource_t'(sample.sw[7:4]);
      end
   end

   always_comb
   begin
      case (source)
         srcCount:    probeWord = status.count;
         srcWrap:     probeWord = status.wrapCount;
         srcReload:   probeWord = status.reloadValue;
         srcSwitches: probeWord = {16'd0, sample.sw};
         // buttons keep their place in the sample
         srcButtons:  probeWord = {11'd0, sample.btnC, sample.btnU, sample.btnD,
                                   sample.btnL, sample.btnR, 16'd0};
         srcStatus:   probeWord = {30'd0, status.irqFlag, status.reloadPulse};
         srcCycles:   probeWord = cycleCount;
         default:     probeWord = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/segDisplay.sv */
`timescale 1ns/1ps
`default_nettype none
`include "harness_defines.svh"

module segDisplay
(
   input  wire logic             selected_clk,
   input  wire logic             res,
   input  wire logic [31:0]      word,
   output displayPkg::segPattern_t seg,
   output displayPkg::anodeVec_t   an
);
   import displayPkg::*;

   localparam int scanWidth = ($clog2(`SCAN_DIV) > 0) ? $clog2(`SCAN_DIV) : 1;

   logic [scanWidth-1:0] scanCount;
   logic                 scanStep;
   digitIndex_t          digitIdx;
   logic [3:0]           nibble;

   assign scanStep = (scanCount == scanWidth'(`SCAN_DIV - 1));

   //////////////////////////////////////////////////////////////
   // Scan timing
   //////////////////////////////////////////////////////////////
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         scanCount <= '0;
         digitIdx  <= '0;
      end
      else
      begin
         if (scanStep)
         begin
            scanCount <= '0;
            if (digitIdx == digitIndex_t'(`NUM_DIGITS - 1))
               digitIdx <= '0;
            else
               digitIdx <= digitIdx + 1'b1;
         end
         else
            scanCount <= scanCount + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////
   // Digit decode
   //////////////////////////////////////////////////////////////

   // Digit 0 is the low nibble
   assign nibble = word[digitIdx*4 +: 4];
   assign seg    = hexFont(nibble);

   always_comb
   begin
      an           = '1;
      an[digitIdx] = 1'b0;
   end

endmodule

`default_nettype wire

/* hw/tickGen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "harness_defines.svh"

module tickGen
(
   input  wire logic                selected_clk,
   input  wire logic                res,
   input  wire harnessPkg::rateCode_t rate,
   input  wire logic                manualTick,
   output logic                     tick
);
   import harnessPkg::*;

   localparam int decWidth = $clog2(`DECADE_DIV);
   localparam logic [decWidth-1:0] decLast = decWidth'(`DECADE_DIV - 1);

   logic [decWidth-1:0] dec0;
   logic [decWidth-1:0] dec1;
   logic [decWidth-1:0] dec2;
   logic                strobe10;
   logic                strobe100;
   logic                strobe1000;
   logic                rawTick;
   logic                rateChanged;
   rateCode_t           prevRate;

   assign strobe10    = (dec0 == decLast);
   assign strobe100   = strobe10 && (dec1 == decLast);
   assign strobe1000  = strobe100 && (dec2 == decLast);
   assign rateChanged = (rate != prevRate);

   //////////////////////////////////////////////////////////////
   // Decade chain, restarted on a rate change
   //////////////////////////////////////////////////////////////
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         dec0     <= '0;
         dec1     <= '0;
         dec2     <= '0;
         prevRate <= rateEvery;
      end
      else
      begin
         prevRate <= rate;
         if (rateChanged)
         begin
            dec0 <= '0;
            dec1 <= '0;
            dec2 <= '0;
         end
         else
         begin
            dec0 <= strobe10 ? '0 : dec0 + 1'b1;
            if (strobe10)
               dec1 <= strobe100 ? '0 : dec1 + 1'b1;
            if (strobe100)
               dec2 <= strobe1000 ? '0 : dec2 + 1'b1;
         end
      end
   end

   always_comb
   begin
      case (rate)
         rateEvery:   rawTick = 1'b1;
         rateDiv10:   rawTick = strobe10;
         rateDiv100:  rawTick = strobe100;
         rateDiv1000: rawTick = strobe1000;
         default:     rawTick = manualTick;
      endcase
   end

   // Held off while the chain restarts
   assign tick = rawTick & ~rateChanged;

endmodule

`default_nettype wire

/* verif/debugTop_golden.txt */
// Columns, all hex: buttons (C U D L R, bit 4 down to 0), switches, hold cycles, check,
// expected display word, expected leds. Check 0 means the line is not compared
00 0000 0014 1 00000000 00C0
// Manual rate, clear, reload value 5
01 F000 0008 0 00000000 0000
00 F000 0008 1 00000000 F080
04 F000 0008 0 00000000 0000
00 F000 0008 1 00000000 F000
08 F005 0008 0 00000000 0000
00 F005 0008 1 00000000 F000
// Twelve manual ticks
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000001 F001
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000002 F002
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000003 F003
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000004 F004
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000005 F005
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000000 F080
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000001 F081
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000002 F082
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000003 F083
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000004 F084
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000005 F085
10 F005 0008 0 00000000 0000
00 F005 0008 1 00000000 F080
// Wrap count, reload value and switches
02 F015 0008 0 00000000 0000
00 F015 0008 1 00000002 F180
02 F025 0008 0 00000000 0000
00 F025 0008 1 00000005 F280
02 F035 0008 0 00000000 0000
00 F035 0008 1 0000F035 F380
00 89AB 0008 1 000089AB F380
00 CDEF 0008 1 0000CDEF F380
00 1234 0008 1 00001234 F380
00 5670 0008 1 00005670 F380
// Sampled buttons, all five at once with clear over tick
02 F045 0008 0 00000000 0000
00 F045 0008 1 00000000 F480
1F F045 0008 1 001F0000 F400
00 F045 0008 1 00000000 F400
02 F025 0008 0 00000000 0000
00 F025 0008 1 00000045 F200
// Rate 1 with reload 999, then clear
08 F3E7 0008 0 00000000 0000
00 F3E7 0008 1 000003E7 F200
02 F307 0008 0 00000000 0000
00 F307 0008 1 00000000 F000
01 1307 0008 0 00000000 0000
00 1307 0190 0 00000000 0000
01 F307 0008 0 00000000 0000
00 F307 0008 0 00000000 0000
04 F307 0008 0 00000000 0000
00 F307 0008 1 00000000 F000

/* verif/debugTop_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "harness_defines.svh"

module debugTop_tb;

   localparam int clkPeriod   = 20;
   localparam int resetCycles = 10;
   localparam int maxSteps    = 128;
   localparam int fieldCount  = 6;
   localparam int scanCycles  = `SCAN_DIV * `NUM_DIGITS;

   logic                   selected_clk;
   logic                   res;
   logic                   btnC;
   logic                   btnU;
   logic                   btnD;
   logic                   btnL;
   logic                   btnR;
   logic [15:0]            sw;
   logic [15:0]            leds;
   logic [7:0]             seg;
   logic [`NUM_DIGITS-1:0] an;

   // Six hex fields per golden line
   logic [31:0] golden [0:maxSteps*fieldCount-1];
   int          stepCount;
   int          holdSum;
   int          errorCount;
   int          checkCount;
   logic        goldenLoaded;

   debugTop UUT
   (
      .selected_clk (selected_clk),
      .res          (res),
      .btnC         (btnC),
      .btnU         (btnU),
      .btnD         (btnD),
      .btnL         (btnL),
      .btnR         (btnR),
      .sw           (sw),
      .leds         (leds),
      .seg          (seg),
      .an           (an)
   );

   initial
   begin
      selected_clk = 1'b0;
      forever #(clkPeriod / 2) selected_clk = ~selected_clk;
   end

   //////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////

   // Standard seven-segment hex font, active low, dp dark
   function automatic logic [7:0] fontPattern(input logic [3:0] nibble);
      case (nibble)
         4'h0: return 8'b1100_0000;
         4'h1: return 8'b1111_1001;
         4'h2: return 8'b1010_0100;
         4'h3: return 8'b1011_0000;
         4'h4: return 8'b1001_1001;
         4'h5: return 8'b1001_0010;
         4'h6: return 8'b1000_0010;
         4'h7: return 8'b1111_1000;
         4'h8: return 8'b1000_0000;
         4'h9: return 8'b1001_0000;
         4'hA: return 8'b1000_1000;
         4'hB: return 8'b1000_0011;
         4'hC: return 8'b1100_0110;
         4'hD: return 8'b1010_0001;
         4'hE: return 8'b1000_0110;
         default: return 8'b1000_1110;
      endcase
   endfunction

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected, input int step);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("CHECK FAILED step %0d: %s = 0x%h, expected 0x%h",
                  step, name, actual, expected);
      end
   endtask

   // One full scan, rebuilding the word digit by digit
   task automatic readDisplay(input int step, output logic [31:0] word);
      logic [`NUM_DIGITS-1:0] seen;
      logic                   found;
      int                     cycle;
      int                     digit;
      int                     lowCount;
      int                     lit;
      int                     n;
      seen = '0;
      word = '0;
      for (cycle = 0; cycle < scanCycles; cycle++)
      begin
         @(negedge selected_clk);
         lowCount = 0;
         lit      = 0;
         for (digit = 0; digit < `NUM_DIGITS; digit++)
         begin
            if (an[digit] === 1'b0)
            begin
               lowCount++;
               lit = digit;
            end
         end
         if (lowCount != 1)
         begin
            errorCount++;
            $display("Step %0d: anode vector %b does not light exactly one digit", step, an);
         end
         else
         begin
            found = 1'b0;
            for (n = 0; n < 16; n++)
            begin
               if (seg === fontPattern(4'(n)))
               begin
                  found             = 1'b1;
                  word[lit*4 +: 4]  = 4'(n);
               end
            end
            if (!found)
            begin
               errorCount++;
               $display("Step %0d: segment pattern %h on digit %0d is not a hex digit",
                        step, seg, lit);
            end
            seen[lit] = 1'b1;
         end
      end
      for (digit = 0; digit < `NUM_DIGITS; digit++)
      begin
         if (!seen[digit])
         begin
            errorCount++;
            $display("Step %0d: digit %0d was never lit during the scan", step, digit);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////
   initial
   begin : mainSequence
      int          step;
      int          base;
      logic [31:0] shownWord;
      res          = 1'b1;
      btnC         = 1'b0;
      btnU         = 1'b0;
      btnD         = 1'b0;
      btnL         = 1'b0;
      btnR         = 1'b0;
      sw           = '0;
      errorCount   = 0;
      checkCount   = 0;
      holdSum      = 0;
      stepCount    = 0;
      goldenLoaded = 1'b0;

      $readmemh("verif/debugTop_golden.txt", golden);
      while (stepCount < maxSteps && !$isunknown(golden[stepCount*fieldCount]))
      begin
         holdSum += golden[stepCount*fieldCount + 2];
         stepCount++;
      end
      goldenLoaded = 1'b1;
      if (stepCount == 0)
      begin
         errorCount++;
         $display("No stimulus lines were read from the golden file");
      end

      // LEDs hold their reset value while res is high
      repeat (resetCycles - 1) @(posedge selected_clk);
      @(negedge selected_clk);
      checkValue("leds in reset", {16'd0, leds}, 32'd0, 0);
      @(posedge selected_clk);
      res <= 1'b0;

      for (step = 0; step < stepCount; step++)
      begin
         base = step * fieldCount;
         @(posedge selected_clk);
         {btnC, btnU, btnD, btnL, btnR} <= golden[base][4:0];
         sw                             <= golden[base + 1][15:0];
         repeat (golden[base + 2]) @(posedge selected_clk);
         if (golden[base + 3] != 0)
         begin
            readDisplay(step + 1, shownWord);
            checkValue("display word", shownWord, golden[base + 4], step + 1);
            checkValue("leds", {16'd0, leds}, golden[base + 5], step + 1);
         end
      end

      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // Limit from the golden holds plus one scan per step
   initial
   begin : watchdog
      longint limitCycles;
      wait (goldenLoaded);
      limitCycles = resetCycles + holdSum + stepCount * (scanCycles + 4) + 500;
      #(limitCycles * clkPeriod);
      $display("Timeout: the run did not finish within %0d clock cycles", limitCycles);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire
